// ==== logic/mdu_consts.svh ====
// width and divider step constants for the multiply/divide unit, included by RTL and testbench
`ifndef MDU_CONSTS_SVH
`define MDU_CONSTS_SVH

// ************************************************************
// architectural widths
// ************************************************************
`define MDU_DATA_W    32 // one general purpose register
`define MDU_DWORD_W   64 // full HI/LO pair
`define MDU_HALF_W    16 // operand half used for partial products

// ************************************************************
// divider
// ************************************************************
`define MDU_DIV_STEPS 32 // one quotient bit per iteration
`define MDU_DIV_CNT_W 5  // wide enough to count MDU_DIV_STEPS iterations

`endif

// ==== logic/mdu_pkg.sv ====
// operation and divider state types shared by the pipeline stages and the testbench
package mdu_pkg;

    // operations understood by the unit, carried with every beat
    typedef enum logic [3:0] {
        OP_MFHI,
        OP_MFLO,
        OP_MTHI,
        OP_MTLO,
        OP_MUL,   // low word of signed product, HI/LO untouched
        OP_MULT,
        OP_MULTU,
        OP_MADD,
        OP_MADDU,
        OP_MSUB,
        OP_MSUBU,
        OP_DIV,
        OP_DIVU
    } mdu_op_e;

    // states of the iterative divider in the second stage
    typedef enum logic [1:0] {
        DIV_IDLE, // accepting beats
        DIV_RUN,  // shift and subtract in progress
        DIV_DONE  // sign fix-up and hand-off
    } div_state_e;

endpackage

// ==== logic/mdu_operand_stage.sv ====
// first pipeline stage of the multiply/divide unit, forms magnitudes, sign flags and partial products
`timescale 1ns/10ps
`include "mdu_consts.svh"

module mdu_operand_stage
    import mdu_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      in_valid_i,
    input  mdu_op_e                   op_i,
    input  logic [`MDU_DATA_W-1:0]    a_i,
    input  logic [`MDU_DATA_W-1:0]    b_i,
    output logic                      in_ready_o,
    output logic                      s1_valid_o,
    output mdu_op_e                   s1_op_o,
    output logic [`MDU_DATA_W-1:0]    s1_a_o,
    output logic [`MDU_DATA_W-1:0]    s1_b_o,
    output logic [`MDU_DWORD_W-1:0]   s1_mullo_o,
    output logic [`MDU_DWORD_W-1:0]   s1_mulhi_o,
    output logic                      s1_neg_o,
    output logic                      s1_rneg_o,
    input  logic                      s1_ready_i
);

    logic                     is_signed;
    logic                     use_abs;
    logic [`MDU_DATA_W-1:0]   a_mag;
    logic [`MDU_DATA_W-1:0]   b_mag;
    logic [`MDU_DATA_W-1:0]   pp_ll;
    logic [`MDU_DATA_W-1:0]   pp_hl;
    logic [`MDU_DATA_W-1:0]   pp_lh;
    logic [`MDU_DATA_W-1:0]   pp_hh;

    // ************************************************************
    // operand conditioning
    // ************************************************************
    assign is_signed = op_i inside {OP_MUL, OP_MULT, OP_MADD, OP_MSUB, OP_DIV};
    // a signed divide by zero keeps raw operands so the divider yields all ones and the dividend
    assign use_abs   = is_signed && !(op_i == OP_DIV && b_i == '0);

    assign a_mag = (use_abs && a_i[`MDU_DATA_W-1]) ? -a_i : a_i;
    assign b_mag = (use_abs && b_i[`MDU_DATA_W-1]) ? -b_i : b_i;

    // unsigned 16 by 16 products, each fits in one word
    assign pp_ll = a_mag[`MDU_HALF_W-1:0] * b_mag[`MDU_HALF_W-1:0];
    assign pp_hl = a_mag[`MDU_DATA_W-1:`MDU_HALF_W] * b_mag[`MDU_HALF_W-1:0];
    assign pp_lh = a_mag[`MDU_HALF_W-1:0] * b_mag[`MDU_DATA_W-1:`MDU_HALF_W];
    assign pp_hh = a_mag[`MDU_DATA_W-1:`MDU_HALF_W] * b_mag[`MDU_DATA_W-1:`MDU_HALF_W];

    // ************************************************************
    // output register
    // ************************************************************
    assign in_ready_o = !s1_valid_o || s1_ready_i; // empty or draining this edge

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            s1_valid_o <= 1'b0;
        end else if (in_ready_o) begin
            s1_valid_o <= in_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_valid_i && in_ready_o) begin
            s1_op_o    <= op_i;
            s1_a_o     <= a_mag;               // raw a_i for moves and unsigned ops
            s1_b_o     <= b_mag;
            s1_mullo_o <= {pp_hl, pp_ll};
            s1_mulhi_o <= {pp_hh, pp_lh};
            s1_neg_o   <= use_abs && (a_i[`MDU_DATA_W-1] ^ b_i[`MDU_DATA_W-1]);
            s1_rneg_o  <= use_abs && (op_i == OP_DIV) && a_i[`MDU_DATA_W-1]; // remainder follows dividend
        end
    end

endmodule

// ==== logic/mdu_divider_stage.sv ====
// second pipeline stage of the multiply/divide unit, restoring divider with pass-through for other ops
`timescale 1ns/10ps
`include "mdu_consts.svh"

module mdu_divider_stage
    import mdu_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      s1_valid_i,
    input  mdu_op_e                   s1_op_i,
    input  logic [`MDU_DATA_W-1:0]    s1_a_i,
    input  logic [`MDU_DATA_W-1:0]    s1_b_i,
    input  logic [`MDU_DWORD_W-1:0]   s1_mullo_i,
    input  logic [`MDU_DWORD_W-1:0]   s1_mulhi_i,
    input  logic                      s1_neg_i,
    input  logic                      s1_rneg_i,
    output logic                      s1_ready_o,
    output logic                      s2_valid_o,
    output mdu_op_e                   s2_op_o,
    output logic [`MDU_DATA_W-1:0]    s2_a_o,
    output logic [`MDU_DWORD_W-1:0]   s2_mullo_o,
    output logic [`MDU_DWORD_W-1:0]   s2_mulhi_o,
    output logic                      s2_neg_o,
    output logic [`MDU_DWORD_W-1:0]   s2_divres_o,
    input  logic                      s2_ready_i
);

    div_state_e                  state;
    logic [`MDU_DIV_CNT_W-1:0]   step_cnt;
    logic [`MDU_DATA_W-1:0]      rem_q;
    logic [`MDU_DATA_W-1:0]      quo_q;
    logic [`MDU_DATA_W-1:0]      dvs_q;
    logic                        rneg_q;
    logic                        is_div;
    logic                        s1_fire;
    logic [`MDU_DATA_W:0]        rem_shift;
    logic [`MDU_DATA_W+1:0]      trial;
    logic [`MDU_DATA_W-1:0]      quo_fix;
    logic [`MDU_DATA_W-1:0]      rem_fix;

    assign is_div     = (s1_op_i == OP_DIV) || (s1_op_i == OP_DIVU);
    assign s1_ready_o = (state == DIV_IDLE) && (!s2_valid_o || s2_ready_i);
    assign s1_fire    = s1_valid_i && s1_ready_o;

    // extra top bit keeps the borrow visible even when the divisor is zero
    assign rem_shift = {rem_q, quo_q[`MDU_DATA_W-1]};
    assign trial     = {1'b0, rem_shift} - {2'b00, dvs_q};

    // no sign fix-up on a zero divisor
    assign quo_fix = (s2_neg_o && dvs_q != '0) ? -quo_q : quo_q;
    assign rem_fix = (rneg_q && dvs_q != '0) ? -rem_q : rem_q;

    // ************************************************************
    // control
    // ************************************************************
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state      <= DIV_IDLE;
            step_cnt   <= '0;
            s2_valid_o <= 1'b0;
        end else begin
            if (s2_valid_o && s2_ready_i) begin
                s2_valid_o <= 1'b0;
            end
            case (state)
                DIV_IDLE: begin
                    if (s1_fire && is_div) begin
                        state    <= DIV_RUN;        // this edge is the load cycle
                        step_cnt <= '0;
                    end else if (s1_fire) begin
                        s2_valid_o <= 1'b1;
                    end
                end
                DIV_RUN: begin
                    step_cnt <= step_cnt + 1'b1;
                    if (step_cnt == `MDU_DIV_CNT_W'(`MDU_DIV_STEPS - 1)) begin
                        state <= DIV_DONE;
                    end
                end
                DIV_DONE: begin
                    s2_valid_o <= 1'b1;             // output drained before the run began
                    state      <= DIV_IDLE;
                end
                default: state <= DIV_IDLE;
            endcase
        end
    end

    // ************************************************************
    // datapath
    // ************************************************************
    always_ff @(posedge clk_i) begin
        if (s1_fire) begin
            s2_op_o    <= s1_op_i;
            s2_a_o     <= s1_a_i;
            s2_mullo_o <= s1_mullo_i;
            s2_mulhi_o <= s1_mulhi_i;
            s2_neg_o   <= s1_neg_i;
            rneg_q     <= s1_rneg_i;
            rem_q      <= '0;
            quo_q      <= s1_a_i;               // dividend shifts out as quotient shifts in
            dvs_q      <= s1_b_i;
        end else if (state == DIV_RUN) begin
            if (trial[`MDU_DATA_W+1]) begin
                rem_q <= rem_shift[`MDU_DATA_W-1:0]; // restore on borrow
                quo_q <= {quo_q[`MDU_DATA_W-2:0], 1'b0};
            end else begin
                rem_q <= trial[`MDU_DATA_W-1:0];
                quo_q <= {quo_q[`MDU_DATA_W-2:0], 1'b1};
            end
        end
        if (state == DIV_DONE) begin
            s2_divres_o <= {rem_fix, quo_fix};
        end
    end

    // the output register never holds a beat while a division is iterating
    assert property (@(posedge clk_i) disable iff (rst_i) (state == DIV_RUN) |-> !s2_valid_o);

    // an accepted divide blocks the first stage for every iteration
    assert property (@(posedge clk_i) disable iff (rst_i)
        (s1_fire && is_div) |=> !s1_ready_o [*`MDU_DIV_STEPS]);

endmodule

// ==== logic/mdu_hilo_stage.sv ====
// last pipeline stage of the multiply/divide unit, finishes the product and updates HI/LO
`timescale 1ns/10ps
`include "mdu_consts.svh"

module mdu_hilo_stage
    import mdu_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      s2_valid_i,
    input  mdu_op_e                   s2_op_i,
    input  logic [`MDU_DATA_W-1:0]    s2_a_i,
    input  logic [`MDU_DWORD_W-1:0]   s2_mullo_i,
    input  logic [`MDU_DWORD_W-1:0]   s2_mulhi_i,
    input  logic                      s2_neg_i,
    input  logic [`MDU_DWORD_W-1:0]   s2_divres_i,
    output logic                      s2_ready_o,
    output logic                      out_valid_o,
    output logic [`MDU_DATA_W-1:0]    res_o,
    output logic [`MDU_DWORD_W-1:0]   hilo_o,
    input  logic                      out_ready_i
);

    logic [`MDU_DATA_W+`MDU_HALF_W-1:0] sum_lo;
    logic [`MDU_DATA_W+`MDU_HALF_W-1:0] sum_hi;
    logic [`MDU_DWORD_W-1:0]            umul;
    logic [`MDU_DWORD_W-1:0]            prod;
    logic [`MDU_DWORD_W-1:0]            hilo_next;
    logic [`MDU_DATA_W-1:0]             res_next;

    // ************************************************************
    // product reduction
    // ************************************************************
    assign sum_lo = {{`MDU_HALF_W{1'b0}}, s2_mullo_i[`MDU_DATA_W-1:0]}
                  + {s2_mullo_i[`MDU_DWORD_W-1:`MDU_DATA_W], {`MDU_HALF_W{1'b0}}};
    assign sum_hi = {{`MDU_HALF_W{1'b0}}, s2_mulhi_i[`MDU_DATA_W-1:0]}
                  + {s2_mulhi_i[`MDU_DWORD_W-1:`MDU_DATA_W], {`MDU_HALF_W{1'b0}}};
    assign umul   = {{`MDU_HALF_W{1'b0}}, sum_lo} + {sum_hi, {`MDU_HALF_W{1'b0}}};
    assign prod   = s2_neg_i ? -umul : umul; // neg is only ever set for signed ops

    // ************************************************************
    // HI/LO update and result select
    // ************************************************************
    always_comb begin
        hilo_next = hilo_o;
        res_next  = '0;
        case (s2_op_i)
            OP_MFHI:            res_next = hilo_o[`MDU_DWORD_W-1:`MDU_DATA_W];
            OP_MFLO:            res_next = hilo_o[`MDU_DATA_W-1:0];
            OP_MTHI:            hilo_next = {s2_a_i, hilo_o[`MDU_DATA_W-1:0]};
            OP_MTLO:            hilo_next = {hilo_o[`MDU_DWORD_W-1:`MDU_DATA_W], s2_a_i};
            OP_MUL:             res_next = prod[`MDU_DATA_W-1:0];
            OP_MULT, OP_MULTU:  hilo_next = prod;
            OP_MADD, OP_MADDU:  hilo_next = hilo_o + prod;
            OP_MSUB, OP_MSUBU:  hilo_next = hilo_o - prod;
            OP_DIV, OP_DIVU:    hilo_next = s2_divres_i; // remainder to HI, quotient to LO
            default: begin
                hilo_next = hilo_o;
                res_next  = '0;
            end
        endcase
    end

    // ************************************************************
    // output beat and HI/LO register
    // ************************************************************
    assign s2_ready_o = !out_valid_o || out_ready_i;

    // hilo_o is the architectural register, it only moves when a new beat loads
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            out_valid_o <= 1'b0;
            hilo_o      <= '0;
        end else if (s2_ready_o) begin
            out_valid_o <= s2_valid_i;
            if (s2_valid_i) begin
                hilo_o <= hilo_next;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (s2_valid_i && s2_ready_o) begin
            res_o <= res_next;
        end
    end

    // a stalled output beat is held unchanged until it is taken
    assert property (@(posedge clk_i) disable iff (rst_i)
        (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(res_o) && $stable(hilo_o)));

endmodule

// ==== logic/mdu_top.sv ====
// top of the multiply/divide unit, chains operand, divider and HI/LO stages with valid/ready
`timescale 1ns/10ps
`include "mdu_consts.svh"

module mdu_top
    import mdu_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      in_valid_i,
    output logic                      in_ready_o,
    input  mdu_op_e                   op_i,
    input  logic [`MDU_DATA_W-1:0]    a_i,
    input  logic [`MDU_DATA_W-1:0]    b_i,
    output logic                      out_valid_o,
    input  logic                      out_ready_i,
    output logic [`MDU_DATA_W-1:0]    res_o,
    output logic [`MDU_DWORD_W-1:0]   hilo_o
);

    // operand stage to divider stage
    logic                      s1_valid;
    logic                      s1_ready;
    mdu_op_e                   s1_op;
    logic [`MDU_DATA_W-1:0]    s1_a;
    logic [`MDU_DATA_W-1:0]    s1_b;
    logic [`MDU_DWORD_W-1:0]   s1_mullo;
    logic [`MDU_DWORD_W-1:0]   s1_mulhi;
    logic                      s1_neg;
    logic                      s1_rneg;

    // divider stage to HI/LO stage
    logic                      s2_valid;
    logic                      s2_ready;
    mdu_op_e                   s2_op;
    logic [`MDU_DATA_W-1:0]    s2_a;
    logic [`MDU_DWORD_W-1:0]   s2_mullo;
    logic [`MDU_DWORD_W-1:0]   s2_mulhi;
    logic                      s2_neg;
    logic [`MDU_DWORD_W-1:0]   s2_divres;

    mdu_operand_stage u_operand (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .in_valid_i (in_valid_i),
        .op_i       (op_i),
        .a_i        (a_i),
        .b_i        (b_i),
        .in_ready_o (in_ready_o),
        .s1_valid_o (s1_valid),
        .s1_op_o    (s1_op),
        .s1_a_o     (s1_a),
        .s1_b_o     (s1_b),
        .s1_mullo_o (s1_mullo),
        .s1_mulhi_o (s1_mulhi),
        .s1_neg_o   (s1_neg),
        .s1_rneg_o  (s1_rneg),
        .s1_ready_i (s1_ready)
    );

    mdu_divider_stage u_divider (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .s1_valid_i  (s1_valid),
        .s1_op_i     (s1_op),
        .s1_a_i      (s1_a),
        .s1_b_i      (s1_b),
        .s1_mullo_i  (s1_mullo),
        .s1_mulhi_i  (s1_mulhi),
        .s1_neg_i    (s1_neg),
        .s1_rneg_i   (s1_rneg),
        .s1_ready_o  (s1_ready),
        .s2_valid_o  (s2_valid),
        .s2_op_o     (s2_op),
        .s2_a_o      (s2_a),
        .s2_mullo_o  (s2_mullo),
        .s2_mulhi_o  (s2_mulhi),
        .s2_neg_o    (s2_neg),
        .s2_divres_o (s2_divres),
        .s2_ready_i  (s2_ready)
    );

    mdu_hilo_stage u_hilo (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .s2_valid_i  (s2_valid),
        .s2_op_i     (s2_op),
        .s2_a_i      (s2_a),
        .s2_mullo_i  (s2_mullo),
        .s2_mulhi_i  (s2_mulhi),
        .s2_neg_i    (s2_neg),
        .s2_divres_i (s2_divres),
        .s2_ready_o  (s2_ready),
        .out_valid_o (out_valid_o),
        .res_o       (res_o),
        .hilo_o      (hilo_o),
        .out_ready_i (out_ready_i)
    );

endmodule

// ==== verification/tb_clock_gen.sv ====
// clock and reset source for the multiply/divide unit testbench, 20 ns period and 10 reset cycles
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o; // 20 ns period
    end

    initial begin
        rst_o = 1'b1;
        repeat (10) @(posedge clk_o);
        rst_o <= 1'b0; // released just after the tenth rising edge
    end

endmodule

// ==== verification/mdu_tb.sv ====
// testbench top that drives random stalled beats into the MDU and checks them against a model
`timescale 1ns/10ps
`include "mdu_consts.svh"

module mdu_tb
    import mdu_pkg::*;
();

    localparam int N_OPS     = 600;
    localparam int RST_CYC   = 10;
    localparam int CYC_LIMIT = N_OPS * (`MDU_DIV_STEPS + 1 + 3) + RST_CYC + 200;

    logic                     clk;
    logic                     rst;
    logic                     in_valid;
    logic                     in_ready;
    mdu_op_e                  op;
    logic [`MDU_DATA_W-1:0]   a;
    logic [`MDU_DATA_W-1:0]   b;
    logic                     out_valid;
    logic                     out_ready;
    logic [`MDU_DATA_W-1:0]   res;
    logic [`MDU_DWORD_W-1:0]  hilo;

    logic [31:0]              lfsr_q;
    logic [`MDU_DWORD_W-1:0]  model_hilo;
    logic [`MDU_DATA_W-1:0]   exp_res[$];
    logic [`MDU_DWORD_W-1:0]  exp_hilo[$];
    mdu_op_e                  exp_op[$];
    int                       n_sent;
    int                       n_out;
    int                       errors;
    int                       cycles;
    logic                     took_in;

    tb_clock_gen u_clk (
        .clk_o (clk),
        .rst_o (rst)
    );

    mdu_top UUT (
        .clk_i       (clk),
        .rst_i       (rst),
        .in_valid_i  (in_valid),
        .in_ready_o  (in_ready),
        .op_i        (op),
        .a_i         (a),
        .b_i         (b),
        .out_valid_o (out_valid),
        .out_ready_i (out_ready),
        .res_o       (res),
        .hilo_o      (hilo)
    );

    // ************************************************************
    // random source
    // ************************************************************
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
    endfunction

    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            val    = {val[30:0], lfsr_q[0]};
        end
        return val;
    endfunction

    // corner words come up often so zero divisors and the most negative word get exercised
    function automatic logic [31:0] rand_operand();
        logic [2:0] kind;
        kind = 3'(draw_bits(3));
        case (kind)
            3'd0:    return 32'h0;
            3'd1:    return 32'h8000_0000;
            3'd2:    return 32'hffff_ffff;
            3'd3:    return draw_bits(8);
            default: return draw_bits(32);
        endcase
    endfunction

    task automatic set_beat(input mdu_op_e o, input logic [31:0] x, input logic [31:0] y);
        op = o;
        a  = x;
        b  = y;
    endtask

    // the first beats are fixed and everything after them is random
    task automatic pick_beat(input int idx);
        logic [3:0] code;
        case (idx)
            0:  set_beat(OP_MFHI, 32'h0, 32'h0);
            1:  set_beat(OP_MFLO, 32'h0, 32'h0);
            2:  set_beat(OP_MTHI, 32'h1234_5678, 32'h0);
            3:  set_beat(OP_MTLO, 32'h9abc_def0, 32'h0);
            4:  set_beat(OP_MFHI, 32'h0, 32'h0);
            5:  set_beat(OP_DIV, 32'h8000_0000, 32'hffff_ffff);
            6:  set_beat(OP_DIV, 32'hffff_fff9, 32'h0);
            7:  set_beat(OP_DIVU, 32'h8000_0003, 32'h0);
            8:  set_beat(OP_DIV, 32'hffff_fff9, 32'h0000_0002);
            9:  set_beat(OP_MULT, 32'h8000_0000, 32'h8000_0000);
            10: set_beat(OP_MADDU, 32'hffff_ffff, 32'hffff_ffff);
            11: set_beat(OP_MSUB, 32'h7fff_ffff, 32'h8000_0000);
            default: begin
                code = 4'(draw_bits(4) % 32'd13);
                set_beat(mdu_op_e'(code), rand_operand(), rand_operand());
            end
        endcase
    endtask

    // ************************************************************
    // reference model
    // ************************************************************
    task automatic model_accept(input mdu_op_e o, input logic [31:0] x, input logic [31:0] y);
        logic [63:0] sprod;
        logic [63:0] uprod;
        longint      sx;
        longint      sy;
        logic [31:0] q;
        logic [31:0] r;
        logic [31:0] rv;
        sprod = {{32{x[31]}}, x} * {{32{y[31]}}, y}; // signed product modulo 2^64
        uprod = {32'h0, x} * {32'h0, y};
        sx    = {{32{x[31]}}, x};
        sy    = {{32{y[31]}}, y};
        q     = '1;                                  // divide by zero gives all ones
        r     = x;                                   // and hands back the dividend
        if (y != '0) begin
            q = (o == OP_DIV) ? 32'(sx / sy) : x / y;
            r = (o == OP_DIV) ? 32'(sx % sy) : x % y;
        end
        rv = '0;
        case (o)
            OP_MFHI:  rv = model_hilo[63:32];
            OP_MFLO:  rv = model_hilo[31:0];
            OP_MTHI:  model_hilo[63:32] = x;
            OP_MTLO:  model_hilo[31:0] = x;
            OP_MUL:   rv = sprod[31:0];
            OP_MULT:  model_hilo = sprod;
            OP_MULTU: model_hilo = uprod;
            OP_MADD:  model_hilo = model_hilo + sprod;
            OP_MADDU: model_hilo = model_hilo + uprod;
            OP_MSUB:  model_hilo = model_hilo - sprod;
            OP_MSUBU: model_hilo = model_hilo - uprod;
            default:  model_hilo = {r, q};           // DIV and DIVU
        endcase
        exp_res.push_back(rv);
        exp_hilo.push_back(model_hilo);
        exp_op.push_back(o);
    endtask

    // the beat on the outputs is taken at the coming rising edge
    task automatic check_output();
        logic [31:0] er;
        logic [63:0] eh;
        mdu_op_e     eo;
        n_out++;
        if (exp_res.size() == 0) begin
            errors++;
            $display("an output beat appeared with no accepted input beat behind it");
            return;
        end
        er = exp_res.pop_front();
        eh = exp_hilo.pop_front();
        eo = exp_op.pop_front();
        assert (res === er) else begin
            errors++;
            $display("error at %0d ns: %s res_o %h, expected %h", $time, eo.name(), res, er);
        end
        assert (hilo === eh) else begin
            errors++;
            $display("error at %0d ns: %s hilo_o %h, expected %h", $time, eo.name(), hilo, eh);
        end
    endtask

    // ************************************************************
    // stimulus and checking
    // ************************************************************
    initial begin
        in_valid   = 1'b0;
        out_ready  = 1'b0;
        op         = OP_MFHI;
        a          = '0;
        b          = '0;
        lfsr_q     = 32'd39;
        model_hilo = '0;
        n_sent     = 0;
        n_out      = 0;
        errors     = 0;
        took_in    = 1'b0;
        @(negedge clk);
        while (rst !== 1'b0) @(negedge clk);
        #5;
        assert (out_valid === 1'b0 && in_ready === 1'b1) else begin
            errors++;
            $display("after reset out_valid_o was not low or in_ready_o was not high");
        end
        while (n_out < N_OPS) begin
            @(negedge clk);
            if (!in_valid || took_in) begin          // a pending beat stays untouched
                if (n_sent < N_OPS && draw_bits(2) != 32'd0) begin
                    pick_beat(n_sent);
                    in_valid = 1'b1;
                end else begin
                    in_valid = 1'b0;
                end
            end
            out_ready = (draw_bits(2) != 32'd0);
            #5;
            took_in = in_valid && in_ready;
            if (took_in) begin
                model_accept(op, a, b);
                n_sent++;
            end
            if (out_valid && out_ready) begin
                check_output();
            end
        end
        repeat (8) begin
            @(negedge clk);
            in_valid  = 1'b0;
            out_ready = 1'b1;
            #5;
            assert (out_valid === 1'b0) else begin
                errors++;
                $display("an extra output beat appeared after every input was answered");
            end
        end
        $display("%0d beats sent, %0d beats checked, %0d errors", n_sent, n_out, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < CYC_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timed out after %0d cycles waiting for outputs, %0d of %0d beats seen",
                 cycles, n_out, N_OPS);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+logic
logic/mdu_pkg.sv
logic/mdu_operand_stage.sv
logic/mdu_divider_stage.sv
logic/mdu_hilo_stage.sv
logic/mdu_top.sv
verification/tb_clock_gen.sv
verification/mdu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the multiply/divide unit testbench with Verilator, run it and scan the log.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
    -f filelist.f --top-module mdu_tb -Mdir obj_dir -o mdu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/mdu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi
exit 0
